// File: logic/mesh_pkg.sv
package mesh_pkg;

  //////////////////////////////////////////////////////////////////////
  // Mesh geometry and address map.
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_TILES  = 4;
  localparam int TILE_ID_W  = 2;
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int TILE_WIN_W = 13;
  localparam logic [ADDR_W-1:0] MESH_LIMIT = 32'h0000_8000;

  // Node internals.
  localparam int FIFO_DEPTH = 2;
  localparam int NUM_PORTS  = 3;

  // Tile n sits at row bit 1 and column bit 0 of n.
  localparam int ROW_BIT = 1;
  localparam int COL_BIT = 0;

  //////////////////////////////////////////////////////////////////////
  // Types.
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Indexes inputs, outputs and grant vectors of a node.
  typedef enum logic [1:0] {
    PORT_LOCAL = 2'd0,
    PORT_ROW   = 2'd1,
    PORT_COL   = 2'd2
  } port_e;

  typedef logic [TILE_ID_W-1:0] tile_id_t;

  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mesh_cmd_t;

  typedef struct packed {
    mesh_cmd_t cmd;
    tile_id_t  src;
    tile_id_t  dst;
  } mesh_flit_t;

endpackage

// File: logic/mesh_input_buffer.sv
`timescale 1ns/1ps

module mesh_input_buffer
  import mesh_pkg::*;
#(
  parameter type flit_t = mesh_flit_t
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  flit_t in_flit_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output flit_t head_flit_o,
  output logic  head_valid_o,
  input  logic  pop_i
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  flit_t            mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready_o   = (count_q < CNT_W'(FIFO_DEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = pop_i && head_valid_o;

  // Storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_flit_i;
    end
  end

  // Pointers and occupancy.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: logic/mesh_addr_decode.sv
`timescale 1ns/1ps

module mesh_addr_decode
  import mesh_pkg::*;
(
  input  logic [ADDR_W-1:0]    addr_i,
  output logic [TILE_ID_W-1:0] dst_o,
  output logic                 off_mesh_o
);

  // Address map, one 8 KiB window per tile.
  //   0x0000 - 0x1fff  tile 0
  //   0x2000 - 0x3fff  tile 1
  //   0x4000 - 0x5fff  tile 2
  //   0x6000 - 0x7fff  tile 3
  //   0x8000 and above has no owner on the mesh.

  always_comb begin
    off_mesh_o = (addr_i >= MESH_LIMIT);
  end

  // Owning tile sits right above the window offset.
  always_comb begin
    dst_o = addr_i[TILE_WIN_W +: TILE_ID_W];
  end

endmodule

// File: logic/mesh_switch_ctrl.sv
`timescale 1ns/1ps

module mesh_switch_ctrl
  import mesh_pkg::*;
#(
  parameter int NODE_ID = 0
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  mesh_flit_t [NUM_PORTS-1:0]           head_flit_i,
  input  logic [NUM_PORTS-1:0]                 head_valid_i,
  input  logic                                 off_mesh_i,
  input  logic [NUM_PORTS-1:0]                 out_free_i,
  output logic [NUM_PORTS-1:0]                 pop_o,
  output logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant_o,
  output logic                                 drop_o
);

  localparam tile_id_t MY_ID = tile_id_t'(NODE_ID);

  // req[out][in] is set when input in wants output out.
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req;
  port_e [NUM_PORTS-1:0]               rr_ptr_q;
  port_e [NUM_PORTS-1:0]               win;
  logic [NUM_PORTS-1:0]                win_valid;

  // Dimension order, column first then row.
  function automatic port_e route(input tile_id_t dst);
    port_e p;
    if (dst[COL_BIT] != MY_ID[COL_BIT]) begin
      p = PORT_ROW;
    end else if (dst[ROW_BIT] != MY_ID[ROW_BIT]) begin
      p = PORT_COL;
    end else begin
      p = PORT_LOCAL;
    end
    return p;
  endfunction

  assign drop_o = head_valid_i[PORT_LOCAL] && off_mesh_i;

  always_comb begin
    req = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (head_valid_i[i] && !((i == int'(PORT_LOCAL)) && off_mesh_i)) begin
        req[route(head_flit_i[i].dst)][i] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Round-robin grant, search starts after the last winner.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    int cand;
    grant_o   = '0;
    win_valid = '0;
    win       = rr_ptr_q;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int k = 1; k <= NUM_PORTS; k++) begin
        cand = (int'(rr_ptr_q[o]) + k) % NUM_PORTS;
        if (out_free_i[o] && req[o][cand] && !win_valid[o]) begin
          grant_o[o][cand] = 1'b1;
          win_valid[o]     = 1'b1;
          win[o]           = port_e'(cand);
        end
      end
    end
  end

  // Winners and dropped local heads leave their buffers.
  always_comb begin
    pop_o = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      pop_o = pop_o | grant_o[o];
    end
    pop_o[PORT_LOCAL] = pop_o[PORT_LOCAL] | drop_o;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        rr_ptr_q[o] <= PORT_COL;
      end
    end else begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (win_valid[o]) begin
          rr_ptr_q[o] <= win[o];
        end
      end
    end
  end

endmodule

// File: logic/mesh_output_reg.sv
`timescale 1ns/1ps

module mesh_output_reg
  import mesh_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  mesh_flit_t [NUM_PORTS-1:0] cand_flit_i,
  input  logic [NUM_PORTS-1:0]       grant_i,
  output logic                       free_o,
  output mesh_flit_t                 out_flit_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i
);

  mesh_flit_t sel_flit;
  logic       load;

  // One-hot grant, so an OR of the masked candidates is enough.
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (grant_i[i]) begin
        sel_flit = sel_flit | cand_flit_i[i];
      end
    end
  end

  assign load   = |grant_i;
  assign free_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_flit_o <= sel_flit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
    end else if (load) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

endmodule

// File: logic/mesh_node.sv
`timescale 1ns/1ps

module mesh_node
  import mesh_pkg::*;
#(
  parameter int NODE_ID = 0
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  mesh_cmd_t  local_cmd_i,
  input  logic       local_valid_i,
  output logic       local_ready_o,
  input  mesh_flit_t row_flit_i,
  input  logic       row_valid_i,
  output logic       row_ready_o,
  input  mesh_flit_t col_flit_i,
  input  logic       col_valid_i,
  output logic       col_ready_o,
  output mesh_flit_t local_flit_o,
  output logic       local_valid_o,
  input  logic       local_ready_i,
  output mesh_flit_t row_flit_o,
  output logic       row_valid_o,
  input  logic       row_ready_i,
  output mesh_flit_t col_flit_o,
  output logic       col_valid_o,
  input  logic       col_ready_i,
  output logic       drop_o
);

  // Local entry keeps the off-mesh flag next to its flit.
  typedef struct packed {
    logic       off_mesh;
    mesh_flit_t flit;
  } local_entry_t;

  logic [TILE_ID_W-1:0]                dec_dst;
  logic                                dec_off;
  local_entry_t                        loc_in;
  local_entry_t                        loc_head;
  mesh_flit_t [NUM_PORTS-1:0]          head_flit;
  logic [NUM_PORTS-1:0]                head_valid;
  logic [NUM_PORTS-1:0]                pop;
  logic [NUM_PORTS-1:0]                free;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant;
  mesh_flit_t [NUM_PORTS-1:0]          out_flit;
  logic [NUM_PORTS-1:0]                out_valid;
  logic [NUM_PORTS-1:0]                out_ready;

  //////////////////////////////////////////////////////////////////////
  // Injection, source stamp and decode.
  //////////////////////////////////////////////////////////////////////

  mesh_addr_decode u_decode (
    .addr_i     (local_cmd_i.addr),
    .dst_o      (dec_dst),
    .off_mesh_o (dec_off)
  );

  assign loc_in.off_mesh = dec_off;
  assign loc_in.flit.cmd = local_cmd_i;
  assign loc_in.flit.src = tile_id_t'(NODE_ID);
  assign loc_in.flit.dst = dec_dst;

  mesh_input_buffer #(.flit_t(local_entry_t)) u_buf_local (
    .clk_i, .rst_i,
    .in_flit_i (loc_in),        .in_valid_i   (local_valid_i),
    .in_ready_o (local_ready_o), .head_flit_o  (loc_head),
    .head_valid_o (head_valid[PORT_LOCAL]), .pop_i (pop[PORT_LOCAL])
  );

  assign head_flit[PORT_LOCAL] = loc_head.flit;

  mesh_input_buffer u_buf_row (
    .clk_i, .rst_i,
    .in_flit_i (row_flit_i),   .in_valid_i   (row_valid_i),
    .in_ready_o (row_ready_o), .head_flit_o  (head_flit[PORT_ROW]),
    .head_valid_o (head_valid[PORT_ROW]), .pop_i (pop[PORT_ROW])
  );

  mesh_input_buffer u_buf_col (
    .clk_i, .rst_i,
    .in_flit_i (col_flit_i),   .in_valid_i   (col_valid_i),
    .in_ready_o (col_ready_o), .head_flit_o  (head_flit[PORT_COL]),
    .head_valid_o (head_valid[PORT_COL]), .pop_i (pop[PORT_COL])
  );

  mesh_switch_ctrl #(.NODE_ID(NODE_ID)) u_ctrl (
    .clk_i, .rst_i,
    .head_flit_i  (head_flit),
    .head_valid_i (head_valid),
    .off_mesh_i   (loc_head.off_mesh),
    .out_free_i   (free),
    .pop_o        (pop),
    .grant_o      (grant),
    .drop_o       (drop_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Output registers, one per port.
  //////////////////////////////////////////////////////////////////////

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
    mesh_output_reg u_out (
      .clk_i, .rst_i,
      .cand_flit_i (head_flit),
      .grant_i     (grant[o]),
      .free_o      (free[o]),
      .out_flit_o  (out_flit[o]),
      .out_valid_o (out_valid[o]),
      .out_ready_i (out_ready[o])
    );
  end

  assign local_flit_o         = out_flit[PORT_LOCAL];
  assign local_valid_o        = out_valid[PORT_LOCAL];
  assign out_ready[PORT_LOCAL] = local_ready_i;
  assign row_flit_o           = out_flit[PORT_ROW];
  assign row_valid_o          = out_valid[PORT_ROW];
  assign out_ready[PORT_ROW]   = row_ready_i;
  assign col_flit_o           = out_flit[PORT_COL];
  assign col_valid_o          = out_valid[PORT_COL];
  assign out_ready[PORT_COL]   = col_ready_i;

endmodule

// File: logic/mesh_top.sv
`timescale 1ns/1ps

module mesh_top
  import mesh_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  mesh_cmd_t [NUM_TILES-1:0]  init_cmd_i,
  input  logic [NUM_TILES-1:0]       init_valid_i,
  output logic [NUM_TILES-1:0]       init_ready_o,
  output mesh_flit_t [NUM_TILES-1:0] tgt_flit_o,
  output logic [NUM_TILES-1:0]       tgt_valid_o,
  input  logic [NUM_TILES-1:0]       tgt_ready_i,
  output logic [NUM_TILES-1:0]       drop_o
);

  //////////////////////////////////////////////////////////////////////
  // Links, indexed by the sending node for flit and valid.
  // Ready is indexed by the receiving node.
  //////////////////////////////////////////////////////////////////////

  mesh_flit_t [NUM_TILES-1:0] row_flit;
  logic [NUM_TILES-1:0]       row_valid;
  logic [NUM_TILES-1:0]       row_ready;
  mesh_flit_t [NUM_TILES-1:0] col_flit;
  logic [NUM_TILES-1:0]       col_valid;
  logic [NUM_TILES-1:0]       col_ready;

  // Row neighbour differs in bit 0, column neighbour in bit 1.
  for (genvar n = 0; n < NUM_TILES; n++) begin : gen_node
    localparam int ROW_NB = n ^ (1 << COL_BIT);
    localparam int COL_NB = n ^ (1 << ROW_BIT);

    mesh_node #(.NODE_ID(n)) u_node (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .local_cmd_i   (init_cmd_i[n]),
      .local_valid_i (init_valid_i[n]),
      .local_ready_o (init_ready_o[n]),
      .row_flit_i    (row_flit[ROW_NB]),
      .row_valid_i   (row_valid[ROW_NB]),
      .row_ready_o   (row_ready[n]),
      .col_flit_i    (col_flit[COL_NB]),
      .col_valid_i   (col_valid[COL_NB]),
      .col_ready_o   (col_ready[n]),
      .local_flit_o  (tgt_flit_o[n]),
      .local_valid_o (tgt_valid_o[n]),
      .local_ready_i (tgt_ready_i[n]),
      .row_flit_o    (row_flit[n]),
      .row_valid_o   (row_valid[n]),
      .row_ready_i   (row_ready[ROW_NB]),
      .col_flit_o    (col_flit[n]),
      .col_valid_o   (col_valid[n]),
      .col_ready_i   (col_ready[COL_NB]),
      .drop_o        (drop_o[n])
    );
  end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Free-running clock, half a period per phase.
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// File: test/mesh_props.sv
`timescale 1ns/1ps

module mesh_props
  import mesh_pkg::*;
(
  input logic                       clk_i,
  input logic                       rst_i,
  input logic [NUM_TILES-1:0]       init_ready_o,
  input mesh_flit_t [NUM_TILES-1:0] tgt_flit_o,
  input logic [NUM_TILES-1:0]       tgt_valid_o,
  input logic [NUM_TILES-1:0]       tgt_ready_i,
  input logic [NUM_TILES-1:0]       drop_o
);

  // The mesh is empty and accepts commands in the first cycle out of reset.
  a_reset_idle: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (tgt_valid_o == '0) && (drop_o == '0) && (init_ready_o == '1))
    else $error("mesh outputs not idle after reset");

  for (genvar t = 0; t < NUM_TILES; t++) begin : gen_tile
    // Target beat holds while it waits for ready.
    a_tgt_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      tgt_valid_o[t] && !tgt_ready_i[t] |=> tgt_valid_o[t] && $stable(tgt_flit_o[t]))
      else $error("target flit changed while stalled on tile %0d", t);

    // Only flits owned by this tile leave on its target port.
    a_tgt_dst: assert property (@(posedge clk_i) disable iff (rst_i)
      tgt_valid_o[t] |-> (tgt_flit_o[t].dst == tile_id_t'(t)))
      else $error("flit for another tile delivered on tile %0d", t);
  end

endmodule

// File: test/mesh_tb.sv
`timescale 1ns/1ps

module mesh_tb
  import mesh_pkg::*;
();

  localparam int RST_CYCLES    = 8;
  localparam int DRIVE_DELAY   = 2;
  localparam int WAIT_LIMIT    = 300;
  localparam int IDLE_CYCLES   = 20;
  localparam int RAND_PER_TILE = 40;
  localparam logic [31:0] OFF_MESH_BASE = 32'h0000_8000;

  logic                       clk;
  logic                       rst;
  mesh_cmd_t [NUM_TILES-1:0]  init_cmd;
  logic [NUM_TILES-1:0]       init_valid;
  logic [NUM_TILES-1:0]       init_ready;
  mesh_flit_t [NUM_TILES-1:0] tgt_flit;
  logic [NUM_TILES-1:0]       tgt_valid;
  logic [NUM_TILES-1:0]       tgt_ready;
  logic [NUM_TILES-1:0]       drop;

  // Expected commands per source and destination in issue order.
  mesh_cmd_t exp_q [NUM_TILES*NUM_TILES][$];
  int        accepted;
  int        delivered;
  int        drops_expected;
  int        drops_seen;
  int        seed;
  bit        result_printed;

  tb_clock u_clock (.clk_o(clk));

  mesh_top dut_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .init_cmd_i   (init_cmd),
    .init_valid_i (init_valid),
    .init_ready_o (init_ready),
    .tgt_flit_o   (tgt_flit),
    .tgt_valid_o  (tgt_valid),
    .tgt_ready_i  (tgt_ready),
    .drop_o       (drop)
  );

  bind mesh_top mesh_props u_props (.*);

  //////////////////////////////////////////////////////////////////////
  // Failure reporting.
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    result_printed = 1'b1;
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_error(input string msg);
    abort_run($sformatf("** Error at %0t ns: %s", $time, msg));
  endtask

  task automatic report_timeout(input string what);
    abort_run($sformatf("Timed out while waiting for %s", what));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scoreboard.
  //////////////////////////////////////////////////////////////////////

  // Window owner comes from address bits 14:13.
  task automatic record_accept(input int t, input mesh_cmd_t c);
    if (c.addr >= OFF_MESH_BASE) begin
      drops_expected++;
    end else begin
      exp_q[t*NUM_TILES + int'(c.addr[14:13])].push_back(c);
      accepted++;
    end
  endtask

  task automatic check_delivery(input int t, input mesh_flit_t f);
    int idx;
    idx = int'(f.src) * NUM_TILES + t;
    assert (int'(f.dst) == t)
      else report_error($sformatf("tile %0d got flit with dst %0d", t, f.dst));
    assert (exp_q[idx].size() > 0)
      else report_error($sformatf("unexpected flit at tile %0d from %0d", t, f.src));
    assert (f.cmd == exp_q[idx][0])
      else report_error($sformatf("tile %0d got %h, expected %h", t, f.cmd, exp_q[idx][0]));
    void'(exp_q[idx].pop_front());
    delivered++;
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      for (int t = 0; t < NUM_TILES; t++) begin
        if (tgt_valid[t] && tgt_ready[t]) begin
          check_delivery(t, tgt_flit[t]);
        end
        if (drop[t]) begin
          drops_seen++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus.
  //////////////////////////////////////////////////////////////////////

  // About one command in eight gets bit 15 set and goes off-mesh.
  function automatic mesh_cmd_t random_cmd(input int t, input int seq);
    mesh_cmd_t c;
    int        r;
    r       = $random(seed);
    c.op    = r[0] ? OP_WRITE : OP_READ;
    c.addr  = {16'h0, (r[31:29] == 3'd0), r[14:0]};
    c.wdata = {8'(t), 24'(seq)};
    return c;
  endfunction

  task automatic send_one(input int t, input mesh_cmd_t c);
    int timer;
    init_cmd[t]   = c;
    init_valid[t] = 1'b1;
    timer         = 0;
    @(posedge clk);
    while (!init_ready[t]) begin
      timer++;
      if (timer > WAIT_LIMIT) begin
        report_timeout($sformatf("init_ready on tile %0d", t));
      end
      @(posedge clk);
    end
    record_accept(t, c);
    #DRIVE_DELAY;
    init_valid[t] = 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int timer;
    timer = 0;
    while (delivered != accepted) begin
      @(posedge clk);
      #DRIVE_DELAY;
      timer++;
      if (timer > WAIT_LIMIT) begin
        report_timeout(what);
      end
    end
  endtask

  task automatic wait_drop(input int t);
    int timer;
    timer = 0;
    while (!drop[t]) begin
      @(posedge clk);
      #DRIVE_DELAY;
      timer++;
      if (timer > WAIT_LIMIT) begin
        report_timeout($sformatf("drop on tile %0d", t));
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    assert (!drop[t]) else report_error($sformatf("drop on tile %0d held past one cycle", t));
  endtask

  // All tiles inject at once with optional random back-pressure at the targets.
  task automatic run_traffic(input int per_tile, input bit random_ready);
    int                   sent [NUM_TILES];
    int                   stall;
    int                   r;
    bit                   busy;
    logic [NUM_TILES-1:0] taken;
    for (int t = 0; t < NUM_TILES; t++) begin
      sent[t] = 0;
    end
    stall = 0;
    busy  = (per_tile > 0);
    while (busy) begin
      for (int t = 0; t < NUM_TILES; t++) begin
        r = $random(seed);
        if (!init_valid[t] && (sent[t] < per_tile) && (r[1:0] != 2'b00)) begin
          init_cmd[t]   = random_cmd(t, sent[t]);
          init_valid[t] = 1'b1;
        end
        tgt_ready[t] = random_ready ? r[4] : 1'b1;
      end
      @(posedge clk);
      taken = init_valid & init_ready;
      #DRIVE_DELAY;
      busy = 1'b0;
      for (int t = 0; t < NUM_TILES; t++) begin
        if (taken[t]) begin
          record_accept(t, init_cmd[t]);
          sent[t]++;
          init_valid[t] = 1'b0;
          stall         = 0;
        end
        if (init_valid[t] || (sent[t] < per_tile)) begin
          busy = 1'b1;
        end
      end
      stall++;
      if (stall > WAIT_LIMIT) begin
        report_timeout("an injection in random traffic");
      end
    end
    tgt_ready = '1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence.
  //////////////////////////////////////////////////////////////////////

  initial begin
    mesh_cmd_t c;
    int        r;
    seed           = 32'h190b24a0;
    rst            = 1'b1;
    init_cmd       = '0;
    init_valid     = '0;
    tgt_ready      = '1;
    accepted       = 0;
    delivered      = 0;
    drops_expected = 0;
    drops_seen     = 0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // Every tile reaches every window.
    for (int src = 0; src < NUM_TILES; src++) begin
      for (int win = 0; win < NUM_TILES; win++) begin
        r       = $random(seed);
        c.op    = r[13] ? OP_WRITE : OP_READ;
        c.addr  = {17'h0, 2'(win), r[12:0]};
        c.wdata = $random(seed);
        send_one(src, c);
        wait_drained($sformatf("delivery from tile %0d to window %0d", src, win));
      end
    end

    // Off-mesh addresses are dropped at the injecting node.
    for (int t = 0; t < NUM_TILES; t++) begin
      r       = $random(seed);
      c.op    = r[0] ? OP_WRITE : OP_READ;
      c.addr  = OFF_MESH_BASE + 32'(r[19:0]);
      c.wdata = $random(seed);
      send_one(t, c);
      wait_drop(t);
      repeat (IDLE_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
    end

    run_traffic(RAND_PER_TILE, 1'b1);
    wait_drained("traffic under back-pressure");
    run_traffic(RAND_PER_TILE, 1'b0);
    wait_drained("concurrent random traffic");

    // Off-mesh heads still queued behind the last deliveries leave here.
    repeat (IDLE_CYCLES) @(posedge clk);
    #DRIVE_DELAY;

    assert (drops_seen == drops_expected)
      else report_error($sformatf("%0d drops, expected %0d", drops_seen, drops_expected));

    result_printed = 1'b1;
    $display("Testbench passed");
    $finish;
  end

  final begin
    if (!result_printed) begin
      $display("Testbench failed");
    end
  end

endmodule

// File: files.f
logic/mesh_pkg.sv
logic/mesh_input_buffer.sv
logic/mesh_addr_decode.sv
logic/mesh_switch_ctrl.sv
logic/mesh_output_reg.sv
logic/mesh_node.sv
logic/mesh_top.sv
test/tb_clock.sv
test/mesh_props.sv
test/mesh_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= mesh_tb
FILELIST ?= files.f
BUILD    ?= obj_dir
PASS_MSG := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
